//--- Bender.yml
package:
  name: icache_subsystem

sources:
  - files:
      - hw/icache_pkg.sv
      - hw/direct_map.sv
      - hw/i_cache.sv
      - hw/axi_read_arbiter.sv
      - hw/cache_flush_ctrl.sv
      - hw/icache_subsystem.sv
  - target: test
    files:
      - dv/axi_mem_model.sv
      - dv/tb_icache_subsystem.sv

//--- dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  logic        clk,
  input  logic        reset,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp
);

  localparam logic [31:0] DATA_MASK   = 32'hA5A5_5A5A;
  localparam logic [31:0] ERROR_BASE  = 32'hF000_0000;
  localparam logic [1:0]  RESP_SLVERR = 2'b10;

  integer seed;
  int ar_wait;
  int r_wait;
  logic r_pending;
  logic ar_fire;
  logic r_fire;
  logic [31:0] addr_q;

  initial begin
    seed      = 35609;
    arready   = 1'b0;
    rvalid    = 1'b0;
    rdata     = '0;
    rresp     = '0;
    r_pending = 1'b0;
    addr_q    = '0;
    r_wait    = 0;
    ar_wait   = $random(seed) & 3;
    forever begin
      @(posedge clk);
      // handshakes as seen by the edge.
      ar_fire = arvalid && arready;
      r_fire  = rvalid && rready;
      if (ar_fire) begin
        addr_q = araddr;
      end
      #1;
      if (reset) begin
        arready   = 1'b0;
        rvalid    = 1'b0;
        r_pending = 1'b0;
      end else begin
        if (ar_fire) begin
          arready   = 1'b0;
          r_pending = 1'b1;
          r_wait    = $random(seed) & 3;
          ar_wait   = $random(seed) & 3;
        end else if (arvalid && !arready) begin
          if (ar_wait == 0) begin
            arready = 1'b1;
          end else begin
            ar_wait--;
          end
        end
        if (r_fire) begin
          rvalid = 1'b0;
        end
        if (r_pending) begin
          if (r_wait == 0) begin
            rvalid    = 1'b1;
            rdata     = addr_q ^ DATA_MASK;  // whole address in the pattern.
            rresp     = (addr_q >= ERROR_BASE) ? RESP_SLVERR : 2'b00;
            r_pending = 1'b0;
          end else begin
            r_wait--;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_icache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_subsystem;

  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] DATA_MASK  = 32'hA5A5_5A5A;
  localparam logic [31:0] ERROR_BASE = 32'hF000_0000;
  localparam logic [2:0]  PROT_INSTR = 3'b101;  // instruction, secure, privileged.
  localparam logic [31:0] ADDR_A     = 32'h0000_1040;
  localparam logic [31:0] ADDR_B     = 32'h0004_1040;  // same index as a.
  localparam logic [31:0] ADDR_ERR   = 32'hF000_0080;

  logic clk;
  logic reset;
  logic [icache_pkg::NUM_PORTS-1:0]                         fetch_valid;
  logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::ADDR_W-1:0] fetch_addr;
  logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::DATA_W-1:0] fetch_data;
  logic [icache_pkg::NUM_PORTS-1:0]                         fetch_ready;
  logic [icache_pkg::NUM_PORTS-1:0]                         fetch_error;
  logic flush_req;
  logic flush_busy;
  logic m_arvalid;
  logic m_arready;
  logic [icache_pkg::ADDR_W-1:0] m_araddr;
  logic [2:0] m_arprot;
  logic m_rvalid;
  logic m_rready;
  logic [icache_pkg::DATA_W-1:0] m_rdata;
  logic [1:0] m_rresp;

  logic [icache_pkg::NUM_PORTS-1:0] port_busy;
  logic exp_hit [icache_pkg::NUM_PORTS];
  logic model_valid [icache_pkg::NUM_PORTS][icache_pkg::NUM_LINES];
  logic [icache_pkg::TAG_W-1:0] model_tag [icache_pkg::NUM_PORTS][icache_pkg::NUM_LINES];
  int busy_len;
  logic r_owed;  // ar accepted, r beat not yet.

  icache_subsystem DUT (
    .clk, .reset, .fetch_valid, .fetch_addr, .fetch_data, .fetch_ready, .fetch_error,
    .flush_req, .flush_busy, .m_arvalid, .m_arready, .m_araddr, .m_arprot,
    .m_rvalid, .m_rready, .m_rdata, .m_rresp
  );

  axi_mem_model u_mem (
    .clk, .reset, .arvalid (m_arvalid), .arready (m_arready), .araddr (m_araddr),
    .rvalid (m_rvalid), .rready (m_rready), .rdata (m_rdata), .rresp (m_rresp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return addr ^ DATA_MASK;
  endfunction

  function automatic logic in_error_region(input logic [31:0] addr);
    return addr >= ERROR_BASE;
  endfunction

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("Fail %s expected %0h actual %0h", test, expected, actual);
    stop_run();
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    stop_run();
  endtask

  // ########################################
  // per port tracking and checks.
  // ########################################

  for (genvar p = 0; p < icache_pkg::NUM_PORTS; p++) begin : g_port
    logic accept_evt;
    logic in_flight;
    logic [31:0] cur_addr;
    int ar_count;  // reads seen for cur_addr.
    int lat;

    assign accept_evt   = fetch_valid[p] && !flush_busy && !in_flight;
    assign port_busy[p] = in_flight;

    always_ff @(posedge clk) begin
      if (reset) begin
        in_flight <= 1'b0;
        cur_addr  <= '0;
        ar_count  <= 0;
        lat       <= 0;
      end else if (accept_evt) begin
        in_flight <= 1'b1;
        cur_addr  <= fetch_addr[p];
        ar_count  <= 0;
        lat       <= 1;
      end else if (in_flight) begin
        lat <= lat + 1;
        if (m_arvalid && m_arready && (m_araddr == cur_addr)) begin
          ar_count <= ar_count + 1;
        end
        if (fetch_ready[p]) begin
          in_flight <= 1'b0;
        end
      end
    end

    read_data: assert property (@(posedge clk) disable iff (reset)
      fetch_ready[p] && !in_error_region(cur_addr) |-> fetch_data[p] == expected_word(cur_addr))
      else report_mismatch("read_data", expected_word($sampled(cur_addr)),
                           $sampled(fetch_data[p]));

    error_flag: assert property (@(posedge clk) disable iff (reset)
      fetch_ready[p] |-> fetch_error[p] == in_error_region(cur_addr))
      else report_mismatch("error_flag", in_error_region($sampled(cur_addr)),
                           $sampled(fetch_error[p]));

    axi_read_count: assert property (@(posedge clk) disable iff (reset)
      fetch_ready[p] |-> ar_count == (exp_hit[p] ? 0 : 1))
      else report_mismatch("axi_read_count", $sampled(exp_hit[p]) ? 0 : 1,
                           $sampled(ar_count));

    // ready is sampled on the third edge after accept.
    hit_latency: assert property (@(posedge clk) disable iff (reset)
      fetch_ready[p] && exp_hit[p] |-> lat == 3)
      else report_mismatch("hit_latency", 3, $sampled(lat));
  end

  always_ff @(posedge clk) begin
    if (reset || !flush_busy) begin
      busy_len <= 0;
    end else begin
      busy_len <= busy_len + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      r_owed <= 1'b0;
    end else if (m_arvalid && m_arready) begin
      r_owed <= 1'b1;
    end else if (m_rvalid && m_rready) begin
      r_owed <= 1'b0;
    end
  end

  ar_prot: assert property (@(posedge clk) disable iff (reset)
    m_arvalid |-> m_arprot == PROT_INSTR)
    else report_mismatch("ar_prot", PROT_INSTR, $sampled(m_arprot));

  // rready only with a read in progress.
  r_ready_open: assert property (@(posedge clk) disable iff (reset)
    m_rready |-> m_arvalid || r_owed)
    else report_mismatch("r_ready_open", 1, $sampled(m_arvalid || r_owed));

  // start cycle plus 64 indices.
  flush_length: assert property (@(posedge clk) disable iff (reset)
    $fell(flush_busy) |-> busy_len == 65)
    else report_mismatch("flush_length", 65, $sampled(busy_len));

  flush_waits_idle: assert property (@(posedge clk) disable iff (reset)
    $rose(flush_busy) |-> port_busy == '0)
    else report_mismatch("flush_waits_idle", 0, $sampled(port_busy));

  // ########################################
  // stimulus.
  // ########################################

  task automatic clear_model();
    for (int p = 0; p < icache_pkg::NUM_PORTS; p++) begin
      for (int i = 0; i < icache_pkg::NUM_LINES; i++) begin
        model_valid[p][i] = 1'b0;
        model_tag[p][i]   = '0;
      end
    end
  endtask

  task automatic wait_ready(input int p);
    int cycles;
    cycles = 0;
    while (!fetch_ready[p] && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!fetch_ready[p]) begin
      report_timeout($sformatf("fetch_ready on port %0d", p));
    end
  endtask

  task automatic run_fetch(input int p, input logic [31:0] addr);
    logic [icache_pkg::INDEX_W-1:0] idx;
    logic [icache_pkg::TAG_W-1:0]   tag;
    idx = addr[icache_pkg::INDEX_W+1:2];
    tag = addr[31:icache_pkg::INDEX_W+2];
    exp_hit[p]     = model_valid[p][idx] && (model_tag[p][idx] == tag);
    fetch_addr[p]  = addr;
    fetch_valid[p] = 1'b1;
    wait_ready(p);
    fetch_valid[p] = 1'b0;
    if (!in_error_region(addr)) begin
      model_valid[p][idx] = 1'b1;  // error responses leave the line alone.
      model_tag[p][idx]   = tag;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_flush_level(input logic level);
    int cycles;
    cycles = 0;
    while (flush_busy != level && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (flush_busy != level) begin
      report_timeout($sformatf("flush_busy to become %0b", level));
    end
  endtask

  task automatic pulse_flush();
    flush_req = 1'b1;
    @(posedge clk);
    #1;
    flush_req = 1'b0;
    wait_flush_level(1'b1);
    wait_flush_level(1'b0);
  endtask

  initial begin
    reset       = 1'b1;
    fetch_valid = '0;
    fetch_addr  = '0;
    flush_req   = 1'b0;
    exp_hit[0]  = 1'b0;
    exp_hit[1]  = 1'b0;
    clear_model();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;

    run_fetch(0, ADDR_A);  // cold miss.
    run_fetch(0, ADDR_A);  // hit.
    run_fetch(0, ADDR_B);  // conflict eviction.
    run_fetch(0, ADDR_A);
    run_fetch(0, ADDR_A);
    run_fetch(0, ADDR_ERR);
    run_fetch(0, ADDR_ERR);

    fork
      run_fetch(0, 32'h0000_2000);
      run_fetch(1, 32'h0000_3004);
    join
    run_fetch(1, 32'h0000_3004);

    // fence arrives while port 1 is still missing.
    fork
      run_fetch(1, 32'h0000_4008);
      begin
        @(posedge clk);
        #1;
        pulse_flush();
      end
    join
    clear_model();
    run_fetch(0, ADDR_A);
    run_fetch(0, 32'h0000_2000);
    run_fetch(1, 32'h0000_3004);
    run_fetch(1, 32'h0000_4008);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/axi_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_arbiter (
  input  logic                                                  clk,
  input  logic                                                  reset,
  // per cache read channels.
  input  logic [icache_pkg::NUM_PORTS-1:0]                      s_arvalid,
  output logic [icache_pkg::NUM_PORTS-1:0]                      s_arready,
  input  logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::ADDR_W-1:0] s_araddr,
  output logic [icache_pkg::NUM_PORTS-1:0]                      s_rvalid,
  input  logic [icache_pkg::NUM_PORTS-1:0]                      s_rready,
  output logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::DATA_W-1:0] s_rdata,
  output logic [icache_pkg::NUM_PORTS-1:0][1:0]                 s_rresp,
  // shared master.
  output logic                                                  m_arvalid,
  input  logic                                                  m_arready,
  output logic [icache_pkg::ADDR_W-1:0]                         m_araddr,
  output logic [2:0]                                            m_arprot,
  input  logic                                                  m_rvalid,
  output logic                                                  m_rready,
  input  logic [icache_pkg::DATA_W-1:0]                         m_rdata,
  input  logic [1:0]                                            m_rresp
);

  logic busy;  // one read in flight.
  logic accept;
  logic [icache_pkg::PORT_W-1:0] rr_ptr;
  logic [icache_pkg::PORT_W-1:0] grant;
  logic [icache_pkg::PORT_W-1:0] pick;

  assign m_arprot = icache_pkg::AXI_PROT_INSTR;
  assign accept   = !busy && (|s_arvalid);

  // ########################################
  // round robin pick.
  // ########################################

  always_comb begin : pick_logic
    int  idx;
    logic found;
    pick  = rr_ptr;
    found = 1'b0;
    for (int k = 0; k < icache_pkg::NUM_PORTS; k++) begin
      idx = (int'(rr_ptr) + k) % icache_pkg::NUM_PORTS;
      if (!found && s_arvalid[idx]) begin
        pick  = idx[icache_pkg::PORT_W-1:0];
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      m_arvalid <= 1'b0;
      grant     <= '0;
      rr_ptr    <= '0;
    end else begin
      if (accept) begin
        busy      <= 1'b1;
        m_arvalid <= 1'b1;
        grant     <= pick;
        // next search starts just past this grant.
        rr_ptr <= (int'(pick) == icache_pkg::NUM_PORTS - 1) ? '0 : pick + 1'b1;
      end else begin
        if (m_arvalid && m_arready) begin
          m_arvalid <= 1'b0;
        end
        if (m_rvalid && m_rready) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      m_araddr <= s_araddr[pick];
    end
  end

  // ########################################
  // steering.
  // ########################################

  assign m_rready = busy && s_rready[grant];

  always_comb begin
    for (int i = 0; i < icache_pkg::NUM_PORTS; i++) begin
      s_arready[i] = accept && (int'(pick) == i);
      s_rvalid[i]  = busy && m_rvalid && (int'(grant) == i);
      s_rdata[i]   = m_rdata;
      s_rresp[i]   = m_rresp;
    end
  end

  no_second_ar: assert property (@(posedge clk) disable iff (reset)
    $rose(m_arvalid) |-> !$past(busy));

endmodule

`default_nettype wire

//--- hw/cache_flush_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_flush_ctrl (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             flush_req,
  input  logic [icache_pkg::NUM_PORTS-1:0] cache_idle,
  output logic                             flush_busy,
  output logic                             flush_valid,
  output logic [icache_pkg::INDEX_W-1:0]   flush_index
);

  logic pending;
  logic walking;
  logic start;
  logic [icache_pkg::INDEX_W-1:0] index_q;

  // busy shows up in the start cycle so no cache accepts a fetch.
  assign start       = pending && !walking && (&cache_idle);
  assign flush_busy  = walking || start;
  assign flush_valid = walking;
  assign flush_index = index_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      walking <= 1'b0;
      index_q <= '0;
    end else begin
      if (start) begin
        pending <= 1'b0;
        walking <= 1'b1;
        index_q <= '0;
      end else if (walking) begin
        index_q <= index_q + 1'b1;
        if (&index_q) begin
          walking <= 1'b0;  // last line done.
        end
      end
      if (flush_req) begin
        pending <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/direct_map.sv
`timescale 1ns/1ps
`default_nettype none

module direct_map (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [icache_pkg::INDEX_W-1:0]   req_index,
  output logic [icache_pkg::TAG_W-1:0]     hit_tag,
  output logic                             hit_valid,
  output logic [icache_pkg::DATA_W-1:0]    data,

  input  logic [icache_pkg::INDEX_W-1:0]   write_index,
  input  logic [icache_pkg::TAG_W-1:0]     write_tag,
  input  logic [icache_pkg::DATA_W-1:0]    write_data,
  input  logic                             write_valid,

  input  logic                             flush_valid,
  input  logic [icache_pkg::INDEX_W-1:0]   flush_index
);

  logic [icache_pkg::TAG_W-1:0]  tag_mem  [icache_pkg::NUM_LINES];
  logic [icache_pkg::DATA_W-1:0] data_mem [icache_pkg::NUM_LINES];
  logic [icache_pkg::NUM_LINES-1:0] valid_bits;

  // ########################################
  // storage.
  // ########################################

  always_ff @(posedge clk) begin
    if (write_valid) begin
      tag_mem[write_index]  <= write_tag;
      data_mem[write_index] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
    end else begin
      if (write_valid) begin
        valid_bits[write_index] <= 1'b1;
      end
      if (flush_valid) begin
        valid_bits[flush_index] <= 1'b0;  // flush wins over fill.
      end
    end
  end

  // ########################################
  // registered lookup.
  // ########################################

  always_ff @(posedge clk) begin
    hit_tag <= tag_mem[req_index];
    data    <= data_mem[req_index];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= valid_bits[req_index];
    end
  end

  // the flush walk only starts once every cache is idle.
  fill_flush_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(write_valid && flush_valid));

endmodule

`default_nettype wire

//--- hw/i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module i_cache (
  input  logic                             clk,
  input  logic                             reset,
  // fetch side.
  input  logic                             fetch_valid,
  input  logic [icache_pkg::ADDR_W-1:0]    fetch_addr,
  output logic [icache_pkg::DATA_W-1:0]    fetch_data,
  output logic                             fetch_ready,
  output logic                             fetch_error,
  output logic                             cache_idle,
  // flush broadcast.
  input  logic                             flush_busy,
  input  logic                             flush_valid,
  input  logic [icache_pkg::INDEX_W-1:0]   flush_index,
  // memory side, axi4-lite read.
  output logic                             arvalid,
  input  logic                             arready,
  output logic [icache_pkg::ADDR_W-1:0]    araddr,
  input  logic                             rvalid,
  output logic                             rready,
  input  logic [icache_pkg::DATA_W-1:0]    rdata,
  input  logic [1:0]                       rresp
);

  typedef enum logic [2:0] {IDLE, LOOKUP, ADDR_SEND, WAIT_DATA, RESPOND} state_t;

  state_t state;
  logic   tag_wait;  // tag store not back yet.
  logic [icache_pkg::ADDR_W-1:0]  addr_q;
  logic [icache_pkg::INDEX_W-1:0] addr_index;
  logic [icache_pkg::TAG_W-1:0]   addr_tag;
  logic [icache_pkg::TAG_W-1:0]   hit_tag;
  logic [icache_pkg::DATA_W-1:0]  cache_data;
  logic hit_valid;
  logic accept, lookup_hit, lookup_miss, r_done, fill;

  assign addr_index = addr_q[icache_pkg::INDEX_W+1:2];
  assign addr_tag   = addr_q[icache_pkg::ADDR_W-1:icache_pkg::INDEX_W+2];

  assign accept      = (state == IDLE) && fetch_valid && !flush_busy;
  assign lookup_hit  = (state == LOOKUP) && !tag_wait && hit_valid && (hit_tag == addr_tag);
  assign lookup_miss = (state == LOOKUP) && !tag_wait && !(hit_valid && (hit_tag == addr_tag));
  assign r_done      = (state == WAIT_DATA) && rvalid && rready;
  assign fill        = r_done && (rresp == icache_pkg::RESP_OKAY);  // no fill on error.

  assign cache_idle = (state == IDLE);
  assign araddr     = addr_q;  // held from accept until respond.

  direct_map u_direct_map (
    .clk,
    .reset,
    .req_index   (addr_index),
    .hit_tag,
    .hit_valid,
    .data        (cache_data),
    .write_index (addr_index),
    .write_tag   (addr_tag),
    .write_data  (rdata),
    .write_valid (fill),
    .flush_valid,
    .flush_index
  );

  // ########################################
  // control fsm.
  // ########################################

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      tag_wait    <= 1'b0;
      fetch_ready <= 1'b0;
      arvalid     <= 1'b0;
      rready      <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state    <= LOOKUP;
            tag_wait <= 1'b1;
          end
        end
        LOOKUP: begin
          tag_wait <= 1'b0;
          if (lookup_hit) begin
            state       <= RESPOND;
            fetch_ready <= 1'b1;
          end else if (lookup_miss) begin
            state   <= ADDR_SEND;
            arvalid <= 1'b1;
          end
        end
        ADDR_SEND: begin
          if (arready) begin
            state   <= WAIT_DATA;
            arvalid <= 1'b0;
            rready  <= 1'b1;
          end
        end
        WAIT_DATA: begin
          if (r_done) begin
            state       <= RESPOND;
            rready      <= 1'b0;
            fetch_ready <= 1'b1;
          end
        end
        RESPOND: begin
          state       <= IDLE;
          fetch_ready <= 1'b0;  // single cycle pulse.
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // payload path.
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_addr;
    end
    if (lookup_hit) begin
      fetch_data  <= cache_data;
      fetch_error <= 1'b0;
    end else if (r_done) begin
      fetch_data  <= rdata;
      fetch_error <= (rresp != icache_pkg::RESP_OKAY);
    end
  end

  ar_stable: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr));

  ready_one_cycle: assert property (@(posedge clk) disable iff (reset)
    fetch_ready |=> !fetch_ready);

endmodule

`default_nettype wire

//--- hw/icache_pkg.sv
package icache_pkg;

  // ########################################
  // fetch side geometry.
  // ########################################

  localparam int NUM_PORTS = 2;  // one cache per fetch port.

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // one word per line, so only index and tag.
  localparam int INDEX_W = 6;
  localparam int NUM_LINES = 2 ** INDEX_W;
  localparam int TAG_W = ADDR_W - INDEX_W - 2;  // 2 byte-offset bits.

  // grant index width, never zero.
  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  // ########################################
  // axi4-lite constants.
  // ########################################

  localparam logic [2:0] AXI_PROT_INSTR = 3'b101;  // instruction, secure, privileged.
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- hw/icache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module icache_subsystem (
  input  logic                                                  clk,
  input  logic                                                  reset,
  // fetch ports.
  input  logic [icache_pkg::NUM_PORTS-1:0]                      fetch_valid,
  input  logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::ADDR_W-1:0] fetch_addr,
  output logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::DATA_W-1:0] fetch_data,
  output logic [icache_pkg::NUM_PORTS-1:0]                      fetch_ready,
  output logic [icache_pkg::NUM_PORTS-1:0]                      fetch_error,
  // fence.
  input  logic                                                  flush_req,
  output logic                                                  flush_busy,
  // axi4-lite read master.
  output logic                                                  m_arvalid,
  input  logic                                                  m_arready,
  output logic [icache_pkg::ADDR_W-1:0]                         m_araddr,
  output logic [2:0]                                            m_arprot,
  input  logic                                                  m_rvalid,
  output logic                                                  m_rready,
  input  logic [icache_pkg::DATA_W-1:0]                         m_rdata,
  input  logic [1:0]                                            m_rresp
);

  logic [icache_pkg::NUM_PORTS-1:0] cache_idle;
  logic flush_valid;
  logic [icache_pkg::INDEX_W-1:0] flush_index;

  logic [icache_pkg::NUM_PORTS-1:0]                         arvalid;
  logic [icache_pkg::NUM_PORTS-1:0]                         arready;
  logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::ADDR_W-1:0] araddr;
  logic [icache_pkg::NUM_PORTS-1:0]                         rvalid;
  logic [icache_pkg::NUM_PORTS-1:0]                         rready;
  logic [icache_pkg::NUM_PORTS-1:0][icache_pkg::DATA_W-1:0] rdata;
  logic [icache_pkg::NUM_PORTS-1:0][1:0]                    rresp;

  cache_flush_ctrl u_flush_ctrl (
    .clk,
    .reset,
    .flush_req,
    .cache_idle,
    .flush_busy,
    .flush_valid,
    .flush_index
  );

  // ########################################
  // one cache per fetch port.
  // ########################################

  for (genvar p = 0; p < icache_pkg::NUM_PORTS; p++) begin : g_cache
    i_cache u_cache (
      .clk,
      .reset,
      .fetch_valid (fetch_valid[p]),
      .fetch_addr  (fetch_addr[p]),
      .fetch_data  (fetch_data[p]),
      .fetch_ready (fetch_ready[p]),
      .fetch_error (fetch_error[p]),
      .cache_idle  (cache_idle[p]),
      .flush_busy,
      .flush_valid,
      .flush_index,
      .arvalid     (arvalid[p]),
      .arready     (arready[p]),
      .araddr      (araddr[p]),
      .rvalid      (rvalid[p]),
      .rready      (rready[p]),
      .rdata       (rdata[p]),
      .rresp       (rresp[p])
    );
  end

  axi_read_arbiter u_arbiter (
    .clk,
    .reset,
    .s_arvalid (arvalid),
    .s_arready (arready),
    .s_araddr  (araddr),
    .s_rvalid  (rvalid),
    .s_rready  (rready),
    .s_rdata   (rdata),
    .s_rresp   (rresp),
    .m_arvalid,
    .m_arready,
    .m_araddr,
    .m_arprot,
    .m_rvalid,
    .m_rready,
    .m_rdata,
    .m_rresp
  );

endmodule

`default_nettype wire

//--- project.f
hw/icache_pkg.sv
hw/direct_map.sv
hw/i_cache.sv
hw/axi_read_arbiter.sv
hw/cache_flush_ctrl.sv
hw/icache_subsystem.sv
dv/axi_mem_model.sv
dv/tb_icache_subsystem.sv
